// File: design/axi_rd_pkg.sv
package axi_rd_pkg;

  // memory depth in 32-bit words
  localparam int MEM_WORDS = 256;

  // beat FIFO entries, which is also the limit on outstanding reads
  localparam int FIFO_DEPTH = 4;

  typedef logic [15:0] addr_t;
  typedef logic [3:0]  id_t;
  typedef logic [7:0]  len_t;
  typedef logic [2:0]  size_t;
  typedef logic [1:0]  burst_t;
  typedef logic [31:0] data_t;
  typedef logic [7:0]  word_idx_t;

  // counts FIFO entries plus reads still in the memory pipeline
  typedef logic [2:0]  credit_t;

  // one AR request as it arrives on the slave port
  typedef struct packed {
    addr_t  addr;
    id_t    id;
    len_t   len;
    size_t  size;
    burst_t burst;
  } ax_req_t;

  // one single-beat read toward the memory
  typedef struct packed {
    addr_t addr;
    id_t   id;
    logic  last;
  } beat_req_t;

  // one read beat on its way back to the R port
  typedef struct packed {
    data_t data;
    id_t   id;
    logic  last;
  } r_beat_t;

  typedef enum logic {
    IDLE,
    BURST
  } iter_state_t;

endpackage

// File: design/burst_iter_ax.sv
`timescale 1ns/1ps

// splits an AXI address burst into single-beat requests
// the outputs are registered, so the first beat leaves one cycle after
// the AR handshake and later beats follow at up to one per cycle
module burst_iter_ax (
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  s_valid,
  input  axi_rd_pkg::ax_req_t   s_req,
  output logic                  s_ready,

  output logic                  m_valid,
  output axi_rd_pkg::beat_req_t m_req,
  input  logic                  m_ready
);

  axi_rd_pkg::iter_state_t state;
  axi_rd_pkg::iter_state_t state_next;

  logic                  s_ready_next;
  logic                  m_valid_next;
  axi_rd_pkg::beat_req_t m_req_next;

  // beats still to come after the one on m_req
  axi_rd_pkg::len_t   burst_len;
  axi_rd_pkg::len_t   burst_len_next;
  axi_rd_pkg::size_t  burst_size;
  axi_rd_pkg::size_t  burst_size_next;
  axi_rd_pkg::burst_t burst_type;
  axi_rd_pkg::burst_t burst_type_next;

  always_comb begin
    state_next      = state;
    s_ready_next    = 1'b0;
    m_valid_next    = m_valid && !m_ready;
    m_req_next      = m_req;
    burst_len_next  = burst_len;
    burst_size_next = burst_size;
    burst_type_next = burst_type;

    case (state)
      axi_rd_pkg::IDLE: begin
        s_ready_next = 1'b1;
        if (s_valid && s_ready) begin
          state_next      = axi_rd_pkg::BURST;
          s_ready_next    = 1'b0;
          m_valid_next    = 1'b1;
          m_req_next.addr = s_req.addr;
          m_req_next.id   = s_req.id;
          m_req_next.last = (s_req.len == '0);
          burst_len_next  = s_req.len;
          burst_size_next = s_req.size;
          burst_type_next = s_req.burst;
        end
      end

      axi_rd_pkg::BURST: begin
        if (m_valid && m_ready) begin
          if (burst_len == '0) begin
            // the last beat just went out, so open up for the next burst
            state_next   = axi_rd_pkg::IDLE;
            s_ready_next = 1'b1;
          end else begin
            m_valid_next    = 1'b1;
            burst_len_next  = burst_len - 1'b1;
            m_req_next.last = (burst_len == axi_rd_pkg::len_t'(1));
            // FIXED bursts keep the start address, WRAP steps like INCR
            if (burst_type != 2'b00) begin
              m_req_next.addr = m_req.addr + (axi_rd_pkg::addr_t'(1) << burst_size);
            end
          end
        end
      end

      default: begin
        state_next = axi_rd_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= axi_rd_pkg::IDLE;
      s_ready <= 1'b1;
      m_valid <= 1'b0;
    end else begin
      state   <= state_next;
      s_ready <= s_ready_next;
      m_valid <= m_valid_next;
    end
  end

  always_ff @(posedge clk) begin
    m_req      <= m_req_next;
    burst_len  <= burst_len_next;
    burst_size <= burst_size_next;
    burst_type <= burst_type_next;
  end

endmodule

// File: design/rd_credit_counter.sv
`timescale 1ns/1ps

// tracks how many beat FIFO entries are spoken for
// a credit is taken when a memory read issues and returned when the beat
// leaves on the R port, so memory data always finds a free FIFO slot
module rd_credit_counter (
  input  logic clk,
  input  logic rst_n,
  input  logic take,
  input  logic give,
  output logic ready
);

  axi_rd_pkg::credit_t count;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count <= '0;
    end else if (take && !give) begin
      count <= count + 1'b1;
    end else if (give && !take) begin
      count <= count - 1'b1;
    end
  end

  // take and give in the same cycle leave the count where it is
  assign ready = (count < axi_rd_pkg::credit_t'(axi_rd_pkg::FIFO_DEPTH));

endmodule

// File: design/word_sram.sv
`timescale 1ns/1ps

// word memory with a backdoor write and a one-cycle registered read
// id and last ride along with the read so the beat comes out complete
module word_sram (
  input  logic                  clk,

  input  logic                  we,
  input  axi_rd_pkg::word_idx_t waddr,
  input  axi_rd_pkg::data_t     wdata,

  input  logic                  re,
  input  axi_rd_pkg::beat_req_t rreq,
  output logic                  rvalid,
  output axi_rd_pkg::r_beat_t   rbeat
);

  axi_rd_pkg::data_t     mem [axi_rd_pkg::MEM_WORDS];
  axi_rd_pkg::word_idx_t ridx;

  // byte address bits 9 to 2 select the word, narrow reads get all of it
  assign ridx = axi_rd_pkg::word_idx_t'(rreq.addr[9:2]);

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // re is held low by the top level while in reset, which clears rvalid
  always_ff @(posedge clk) begin
    rvalid <= re;
  end

  always_ff @(posedge clk) begin
    if (re) begin
      rbeat.data <= mem[ridx];
      rbeat.id   <= rreq.id;
      rbeat.last <= rreq.last;
    end
  end

endmodule

// File: design/r_beat_fifo.sv
`timescale 1ns/1ps

// circular buffer for returned read beats
// the head entry drives the R port directly and stays put until taken
module r_beat_fifo (
  input  logic                clk,
  input  logic                rst_n,

  input  logic                push,
  input  axi_rd_pkg::r_beat_t din,

  output logic                valid,
  output axi_rd_pkg::r_beat_t dout,
  input  logic                ready
);

  axi_rd_pkg::r_beat_t entries [axi_rd_pkg::FIFO_DEPTH];

  // the depth is a power of two, so the pointers wrap on their own
  logic [$clog2(axi_rd_pkg::FIFO_DEPTH)-1:0] wr_ptr;
  logic [$clog2(axi_rd_pkg::FIFO_DEPTH)-1:0] rd_ptr;
  axi_rd_pkg::credit_t                       count;
  logic                                      pop;

  assign pop   = valid && ready;
  assign valid = (count != '0);
  assign dout  = entries[rd_ptr];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // no full check here because the credit counter never lets pushes
  // outrun the free entries
  always_ff @(posedge clk) begin
    if (push) begin
      entries[wr_ptr] <= din;
    end
  end

endmodule

// File: design/axi_rd_bridge.sv
`timescale 1ns/1ps

// AXI read bridge
// AR bursts are cut into single beats, read from the word memory and
// returned on R through a FIFO whose space is reserved before each read
module axi_rd_bridge (
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  ar_valid,
  input  axi_rd_pkg::ax_req_t   ar_req,
  output logic                  ar_ready,

  output logic                  r_valid,
  output axi_rd_pkg::r_beat_t   r_beat,
  input  logic                  r_ready,

  input  logic                  mem_we,
  input  axi_rd_pkg::word_idx_t mem_waddr,
  input  axi_rd_pkg::data_t     mem_wdata
);

  logic                  issue_valid;
  logic                  issue_ready;
  axi_rd_pkg::beat_req_t issue_req;
  logic                  issue_fire;
  logic                  mem_re;
  logic                  r_fire;

  logic                  rd_valid;
  axi_rd_pkg::r_beat_t   rd_beat;

  assign issue_fire = issue_valid && issue_ready;
  assign r_fire     = r_valid && r_ready;

  // the memory has no reset of its own, so reads are blocked during reset
  assign mem_re = issue_fire && rst_n;

  burst_iter_ax i_burst_iter_ax (
    .clk     (clk),
    .rst_n   (rst_n),
    .s_valid (ar_valid),
    .s_req   (ar_req),
    .s_ready (ar_ready),
    .m_valid (issue_valid),
    .m_req   (issue_req),
    .m_ready (issue_ready)
  );

  rd_credit_counter i_rd_credit_counter (
    .clk   (clk),
    .rst_n (rst_n),
    .take  (issue_fire),
    .give  (r_fire),
    .ready (issue_ready)
  );

  word_sram i_word_sram (
    .clk    (clk),
    .we     (mem_we),
    .waddr  (mem_waddr),
    .wdata  (mem_wdata),
    .re     (mem_re),
    .rreq   (issue_req),
    .rvalid (rd_valid),
    .rbeat  (rd_beat)
  );

  r_beat_fifo i_r_beat_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (rd_valid),
    .din   (rd_beat),
    .valid (r_valid),
    .dout  (r_beat),
    .ready (r_ready)
  );

endmodule

// File: testbench/tb_clk_gen.sv
`timescale 1ns/1ps

// free-running 8 ns clock and a synchronous reset held low for 16 cycles
module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever begin
      #4;
      clk = ~clk;
    end
  end

  // reset is released just after an edge so the DUT sees a clean deassertion
  initial begin
    rst_n = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

endmodule

// File: testbench/axi_rd_bridge_tb.sv
`timescale 1ns/1ps

module axi_rd_bridge_tb;

  localparam int NUM_BURSTS    = 40;
  localparam int RESET_TIMEOUT = 100;
  localparam int AR_TIMEOUT    = 500;
  localparam int DRAIN_TIMEOUT = 2000;

  logic                  clk;
  logic                  rst_n;
  logic                  ar_valid;
  axi_rd_pkg::ax_req_t   ar_req;
  logic                  ar_ready;
  logic                  r_valid;
  axi_rd_pkg::r_beat_t   r_beat;
  logic                  r_ready;
  logic                  mem_we;
  axi_rd_pkg::word_idx_t mem_waddr;
  axi_rd_pkg::data_t     mem_wdata;

  logic [31:0]         lfsr = 32'h6ec4e0fd;
  axi_rd_pkg::data_t   mirror [axi_rd_pkg::MEM_WORDS];
  axi_rd_pkg::r_beat_t expected_q [$];

  // beats of the current burst that the iterator has not issued yet
  int pending_issue = 0;

  logic                hold_valid = 1'b0;
  axi_rd_pkg::r_beat_t held_beat;

  int  data_errors     = 0;
  int  beat_errors     = 0;
  int  protocol_errors = 0;
  int  timeout_errors  = 0;
  bit  timed_out       = 1'b0;

  tb_clk_gen i_tb_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  axi_rd_bridge i_axi_rd_bridge (
    .clk       (clk),
    .rst_n     (rst_n),
    .ar_valid  (ar_valid),
    .ar_req    (ar_req),
    .ar_ready  (ar_ready),
    .r_valid   (r_valid),
    .r_beat    (r_beat),
    .r_ready   (r_ready),
    .mem_we    (mem_we),
    .mem_waddr (mem_waddr),
    .mem_wdata (mem_wdata)
  );

  // 32-bit Fibonacci LFSR with taps 32 22 2 and 1
  function automatic logic [31:0] next_lfsr(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = next_lfsr(lfsr);
      val  = {val[30:0], lfsr[0]};
    end
    return val;
  endfunction

  // expected beats follow the AXI address rules and FIXED bursts repeat the start
  task automatic push_expected(input axi_rd_pkg::ax_req_t req);
    axi_rd_pkg::r_beat_t beat;
    axi_rd_pkg::addr_t   addr;
    for (int i = 0; i <= int'(req.len); i++) begin
      if (req.burst == 2'b00) begin
        addr = req.addr;
      end else begin
        addr = req.addr + axi_rd_pkg::addr_t'(i << req.size);
      end
      beat.data = mirror[addr[9:2]];
      beat.id   = req.id;
      beat.last = (i == int'(req.len));
      expected_q.push_back(beat);
    end
  endtask

  task automatic check_beat(input axi_rd_pkg::r_beat_t got);
    axi_rd_pkg::r_beat_t exp;
    assert (expected_q.size() != 0) else begin
      beat_errors++;
      $display("FAIL @ %0t: R beat with id %0h arrived with no beat expected", $time, got.id);
    end
    if (expected_q.size() != 0) begin
      exp = expected_q.pop_front();
      assert (got.data == exp.data) else begin
        data_errors++;
        $display("FAIL @ %0t: R data %h, expected %h", $time, got.data, exp.data);
      end
      assert (got.id == exp.id) else begin
        beat_errors++;
        $display("FAIL @ %0t: R id %0h, expected %0h", $time, got.id, exp.id);
      end
      assert (got.last == exp.last) else begin
        beat_errors++;
        $display("FAIL @ %0t: R last %0b, expected %0b", $time, got.last, exp.last);
      end
    end
  endtask

  // everything is sampled on the falling edge halfway between drive points
  always @(negedge clk) begin
    if (rst_n) begin
      if (hold_valid) begin
        assert (r_valid && r_beat == held_beat) else begin
          protocol_errors++;
          $display("FAIL @ %0t: R beat changed while stalled by r_ready", $time);
        end
      end
      hold_valid = r_valid && !r_ready;
      held_beat  = r_beat;

      if (r_valid && r_ready) begin
        check_beat(r_beat);
      end

      assert (!ar_ready || pending_issue == 0) else begin
        protocol_errors++;
        $display("FAIL @ %0t: ar_ready high with %0d beats left to issue", $time,
                 pending_issue);
      end

      if (i_axi_rd_bridge.issue_valid && i_axi_rd_bridge.issue_ready) begin
        assert (pending_issue > 0) else begin
          protocol_errors++;
          $display("FAIL @ %0t: memory read issued outside a burst", $time);
        end
        assert (i_axi_rd_bridge.issue_req.last == (pending_issue == 1)) else begin
          protocol_errors++;
          $display("FAIL @ %0t: issue last flag wrong with %0d beats left", $time,
                   pending_issue);
        end
        pending_issue--;
      end

      if (ar_valid && ar_ready) begin
        push_expected(ar_req);
        pending_issue = int'(ar_req.len) + 1;
      end
    end
  end

  // r_ready is high about three cycles in four
  initial begin
    r_ready = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      if (rst_n) begin
        r_ready = (take_bits(2) != 32'd0);
      end
    end
  end

  task automatic fill_memory();
    axi_rd_pkg::data_t word;
    for (int i = 0; i < axi_rd_pkg::MEM_WORDS; i++) begin
      @(posedge clk);
      word = take_bits(32);
      #1;
      mem_we    = 1'b1;
      mem_waddr = axi_rd_pkg::word_idx_t'(i);
      mem_wdata = word;
      mirror[i] = word;
    end
    @(posedge clk);
    #1;
    mem_we = 1'b0;
  endtask

  task automatic send_burst();
    axi_rd_pkg::ax_req_t req;
    int                  span;
    int                  start;
    int                  waited;
    @(posedge clk);
    req.len   = axi_rd_pkg::len_t'(take_bits(4));
    req.size  = axi_rd_pkg::size_t'(take_bits(2));
    if (req.size == 3'd3) begin
      req.size = 3'd2;
    end
    req.burst = axi_rd_pkg::burst_t'(take_bits(2));
    req.id    = axi_rd_pkg::id_t'(take_bits(4));
    // keep the whole burst inside the 1 KiB memory and aligned to the size
    span      = (int'(req.len) + 1) << req.size;
    start     = int'(take_bits(10)) % (1024 - span + 1);
    start     = start & ~((1 << req.size) - 1);
    req.addr  = axi_rd_pkg::addr_t'(start);
    #1;
    ar_req   = req;
    ar_valid = 1'b1;
    waited   = 0;
    while (!ar_ready && waited < AR_TIMEOUT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (!ar_ready) begin
      timeout_errors++;
      timed_out = 1'b1;
      $display("timed out after %0d cycles waiting for ar_ready to accept a burst", waited);
      ar_valid = 1'b0;
    end else begin
      @(posedge clk);
      #1;
      ar_valid = 1'b0;
    end
  endtask

  task automatic drain_beats();
    int waited;
    waited = 0;
    while ((expected_q.size() != 0 || pending_issue != 0) && waited < DRAIN_TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (expected_q.size() != 0 || pending_issue != 0) begin
      timeout_errors++;
      timed_out = 1'b1;
      $display("timed out waiting for the last read beats, %0d still expected",
               expected_q.size());
    end else begin
      // the last expected beat leaves on this edge, so nothing may follow it
      @(negedge clk);
      assert (!r_valid) else begin
        beat_errors++;
        $display("FAIL @ %0t: R beat still valid after the last expected beat", $time);
      end
    end
  endtask

  initial begin
    int waited;
    ar_valid  = 1'b0;
    ar_req    = '0;
    mem_we    = 1'b0;
    mem_waddr = '0;
    mem_wdata = '0;

    waited = 0;
    while (rst_n !== 1'b1 && waited < RESET_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (rst_n !== 1'b1) begin
      timeout_errors++;
      timed_out = 1'b1;
      $display("timed out waiting for reset to be released");
    end

    if (!timed_out) begin
      // no clock edge has passed since the release, so these are the reset values
      assert (ar_ready && !r_valid) else begin
        protocol_errors++;
        $display("FAIL @ %0t: after reset ar_ready %0b r_valid %0b", $time, ar_ready,
                 r_valid);
      end
      fill_memory();
    end

    for (int n = 0; n < NUM_BURSTS; n++) begin
      if (!timed_out) begin
        send_burst();
      end
    end
    if (!timed_out) begin
      drain_beats();
    end

    $display("errors: data %0d, beat %0d, protocol %0d, timeout %0d", data_errors,
             beat_errors, protocol_errors, timeout_errors);
    if (data_errors + beat_errors + protocol_errors + timeout_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: all.f
design/axi_rd_pkg.sv
design/burst_iter_ax.sv
design/rd_credit_counter.sv
design/word_sram.sv
design/r_beat_fifo.sv
design/axi_rd_bridge.sv
testbench/tb_clk_gen.sv
testbench/axi_rd_bridge_tb.sv

// File: Makefile
TOP := axi_rd_bridge_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log
